// ==== retire_unit.f ====
logic/core_pkg.sv
logic/mem_pkg.sv
logic/stage_reg.sv
logic/data_mem.sv
logic/mem_stage.sv
logic/wb_stage.sv
logic/regfile.sv
logic/retire_unit.sv
verif/retire_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the retire unit testbench with Verilator, run it, then scan the log
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module retire_unit_tb \
  -f retire_unit.f \
  -o retire_unit_sim

./obj_dir/retire_unit_sim | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
  echo "simulation reported failure"
  exit 1
fi

echo "simulation finished without failure"

// ==== verif/retire_unit_tb.sv ====
// retire_unit_tb: random record stimulus, shadow register and memory models, commit checks
`timescale 1ns/10ps
`default_nettype none

module retire_unit_tb
  import core_pkg::*;
  import mem_pkg::*;
();

  localparam int clk_period   = 100;
  localparam int region_words = 16;
  localparam logic [xlen-1:0] region_base = 64'h200;
  localparam int n_exe        = 40;
  localparam int n_ls_rounds  = 20;
  localparam int n_csr        = 30;
  localparam int n_bypass     = 30;
  localparam int n_uart       = 30;
  // window fill plus three records per load/store round
  localparam int n_records =
    n_exe + region_words + 3 * n_ls_rounds + n_csr + n_bypass + n_uart;

  // what the commit side must show for one record
  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] pc;
    logic [31:0]     inst;
    logic            wen;
    reg_addr_t       rd;
    logic [xlen-1:0] data;
    logic            uart_valid;
    logic [7:0]      uart_char;
  } commit_t;

  logic            clk = 1'b0;
  logic            rst;
  logic            in_valid;
  logic [xlen-1:0] in_pc;
  logic [31:0]     in_inst;
  logic            in_wen;
  reg_addr_t       in_rd;
  reg_ctrl_t       in_reg_ctrl;
  logic [xlen-1:0] in_ex_data;
  logic [xlen-1:0] in_csr_data;
  logic            in_uart_valid;
  logic [7:0]      in_uart_char;
  logic            in_mem_ren;
  logic            in_mem_wen;
  mem_size_t       in_mem_size;
  logic            in_mem_unsigned;
  logic [xlen-1:0] in_store_data;
  logic            in_ready;
  reg_addr_t       rs1_addr = '0;
  logic [xlen-1:0] rs1_data;
  reg_addr_t       rs2_addr = '0;
  logic [xlen-1:0] rs2_data;
  logic            reg_wr_ena;
  reg_addr_t       reg_wr_addr;
  logic [xlen-1:0] reg_wr_data;
  logic            commit_valid;
  logic [xlen-1:0] commit_pc;
  logic [31:0]     commit_inst;
  logic            uart_out_valid;
  logic [7:0]      uart_out_char;

  logic [xlen-1:0] exp_data;
  commit_t         exp_in;
  commit_t         exp_s1;
  commit_t         exp_s2;
  logic [xlen-1:0] exp_rs1;
  logic [xlen-1:0] exp_rs2;
  logic [xlen-1:0] sh_regs [32];
  logic [7:0]      sh_mem [region_words * 8];
  logic [31:0]     lcg_state = 32'd75;
  logic            rst_q = 1'b0;
  int              issued = 0;
  int              committed = 0;
  int              errors = 0;
  int              passed = 0;
  int              failed = 0;

  retire_unit #(
    .DMEM_WORDS(dmem_words)
  ) dut0 (
    .clk(clk), .rst(rst), .in_valid(in_valid), .in_pc(in_pc), .in_inst(in_inst),
    .in_wen(in_wen), .in_rd(in_rd), .in_reg_ctrl(in_reg_ctrl), .in_ex_data(in_ex_data),
    .in_csr_data(in_csr_data), .in_uart_valid(in_uart_valid), .in_uart_char(in_uart_char),
    .in_mem_ren(in_mem_ren), .in_mem_wen(in_mem_wen), .in_mem_size(in_mem_size),
    .in_mem_unsigned(in_mem_unsigned), .in_store_data(in_store_data), .in_ready(in_ready),
    .rs1_addr(rs1_addr), .rs1_data(rs1_data), .rs2_addr(rs2_addr), .rs2_data(rs2_data),
    .reg_wr_ena(reg_wr_ena), .reg_wr_addr(reg_wr_addr), .reg_wr_data(reg_wr_data),
    .commit_valid(commit_valid), .commit_pc(commit_pc), .commit_inst(commit_inst),
    .uart_out_valid(uart_out_valid), .uart_out_char(uart_out_char)
  );

  always #(clk_period / 2) clk = ~clk;

  assign exp_in = '{valid: in_valid, pc: in_pc, inst: in_inst, wen: in_wen, rd: in_rd,
                    data: exp_data, uart_valid: in_uart_valid, uart_char: in_uart_char};

  // two-edge latency model of the retire path
  always @(posedge clk) begin
    rst_q <= rst;
    if (rst) begin
      exp_s1 <= '0;
      exp_s2 <= '0;
    end else begin
      exp_s1 <= exp_in;
      exp_s2 <= exp_s1;
    end
    if (!rst && commit_valid) begin
      committed <= committed + 1;
    end
  end

  // shadow registers take the write one edge after commit
  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        sh_regs[i] <= '0;
      end
    end else if (exp_s2.valid && exp_s2.wen && exp_s2.rd != '0) begin
      sh_regs[exp_s2.rd] <= exp_s2.data;
    end
  end

  // rs1 watches the register committing now, rs2 the one just committed
  always @(posedge clk) begin
    if (rst) begin
      rs1_addr <= '0;
      rs2_addr <= '0;
    end else begin
      rs1_addr <= exp_s1.rd;
      rs2_addr <= exp_s2.rd;
    end
  end

  function automatic logic [xlen-1:0] expect_read(input reg_addr_t a);
    if (a == '0) begin
      return '0;
    end
    if (exp_s2.valid && exp_s2.wen && exp_s2.rd == a) begin
      return exp_s2.data;
    end
    return sh_regs[a];
  endfunction

  always_comb begin
    exp_rs1 = expect_read(rs1_addr);
    exp_rs2 = expect_read(rs2_addr);
  end

  task automatic note_mismatch(input string what);
    errors++;
    $display("MISMATCH at %0t: %s", $time, what);
  endtask

  commit_valid_a: assert property (
    @(posedge clk) disable iff (rst) commit_valid == exp_s2.valid
  ) else note_mismatch("commit_valid does not follow the accepted records");

  commit_id_a: assert property (
    @(posedge clk) disable iff (rst)
    exp_s2.valid |-> (commit_pc == exp_s2.pc) && (commit_inst == exp_s2.inst)
  ) else note_mismatch("commit_pc or commit_inst wrong");

  reg_write_ena_a: assert property (
    @(posedge clk) disable iff (rst) reg_wr_ena == (exp_s2.valid && exp_s2.wen)
  ) else note_mismatch("reg_wr_ena wrong");

  reg_write_a: assert property (
    @(posedge clk) disable iff (rst)
    (exp_s2.valid && exp_s2.wen) |-> (reg_wr_addr == exp_s2.rd) && (reg_wr_data == exp_s2.data)
  ) else note_mismatch("reg_wr_addr or reg_wr_data wrong");

  uart_valid_a: assert property (
    @(posedge clk) disable iff (rst) uart_out_valid == (exp_s2.valid && exp_s2.uart_valid)
  ) else note_mismatch("uart_out_valid wrong");

  uart_char_a: assert property (
    @(posedge clk) disable iff (rst) uart_out_valid |-> uart_out_char == exp_s2.uart_char
  ) else note_mismatch("uart_out_char wrong");

  rs_read_a: assert property (
    @(posedge clk) disable iff (rst) (rs1_data == exp_rs1) && (rs2_data == exp_rs2)
  ) else note_mismatch("register read port data wrong");

  reset_quiet_a: assert property (
    @(posedge clk) rst_q |-> !commit_valid && !reg_wr_ena && !uart_out_valid
  ) else note_mismatch("outputs active during or right after reset");

  ready_a: assert property (@(posedge clk) in_ready)
    else note_mismatch("in_ready low");

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [xlen-1:0] random_dword();
    logic [31:0] hi;
    hi = next_random();
    return {hi, next_random()};
  endfunction

  function automatic mem_size_t random_size();
    return mem_size_t'(2'(next_random() >> 30));
  endfunction

  // byte offset in the test window, aligned to the access size
  function automatic int aligned_offset(input mem_size_t sz);
    int off;
    off = int'((next_random() >> 16) % (region_words * 8));
    return off & ~((1 << sz) - 1);
  endfunction

  // plain exe_to_reg write, no memory access, no serial character
  function automatic ex_rec_t random_record();
    ex_rec_t r;
    r.pc = random_dword();
    r.inst = next_random();
    r.wen = 1'b1;
    r.rd = reg_addr_t'(next_random() >> 27);
    r.reg_ctrl = reg_ctrl_t'(1 << exe_to_reg);
    r.ex_data = random_dword();
    r.csr_data = random_dword();
    r.uart_valid = 1'b0;
    r.uart_char = 8'(next_random() >> 20);
    r.mem_ren = 1'b0;
    r.mem_wen = 1'b0;
    r.mem_size = mem_byte;
    r.mem_unsigned = 1'b0;
    r.store_data = random_dword();
    return r;
  endfunction

  function automatic logic [xlen-1:0] load_value(input int off, input mem_size_t sz,
                                                input logic uns);
    int n;
    logic [xlen-1:0] v;
    n = 1 << sz;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[i*8 +: 8] = sh_mem[off + i];
    end
    // sign fill above the loaded bytes
    if (!uns && v[n*8-1]) begin
      for (int i = n; i < 8; i++) begin
        v[i*8 +: 8] = 8'hff;
      end
    end
    return v;
  endfunction

  task automatic store_bytes(input int off, input mem_size_t sz, input logic [xlen-1:0] d);
    for (int i = 0; i < (1 << sz); i++) begin
      sh_mem[off + i] = d[i*8 +: 8];
    end
  endtask

  task automatic send(input ex_rec_t r, input logic [xlen-1:0] expected);
    @(posedge clk);
    in_valid <= 1'b1;
    in_pc <= r.pc;
    in_inst <= r.inst;
    in_wen <= r.wen;
    in_rd <= r.rd;
    in_reg_ctrl <= r.reg_ctrl;
    in_ex_data <= r.ex_data;
    in_csr_data <= r.csr_data;
    in_uart_valid <= r.uart_valid;
    in_uart_char <= r.uart_char;
    in_mem_ren <= r.mem_ren;
    in_mem_wen <= r.mem_wen;
    in_mem_size <= r.mem_size;
    in_mem_unsigned <= r.mem_unsigned;
    in_store_data <= r.store_data;
    exp_data <= expected;
    issued++;
  endtask

  task automatic drain();
    @(posedge clk);
    in_valid <= 1'b0;
    while (committed != issued) begin
      @(posedge clk);
    end
  endtask

  task automatic send_store(input int off, input mem_size_t sz);
    ex_rec_t r;
    r = random_record();
    r.wen = 1'b0;
    r.reg_ctrl = '0;
    r.mem_wen = 1'b1;
    r.mem_size = sz;
    r.ex_data = region_base + 64'(off);
    store_bytes(off, sz, r.store_data);
    send(r, '0);
  endtask

  task automatic send_load(input int off, input mem_size_t sz, input logic uns);
    ex_rec_t r;
    r = random_record();
    r.reg_ctrl = reg_ctrl_t'(1 << mem_to_reg);
    r.mem_ren = 1'b1;
    r.mem_size = sz;
    r.mem_unsigned = uns;
    r.ex_data = region_base + 64'(off);
    send(r, load_value(off, sz, uns));
  endtask

  task automatic run_load_store();
    int off;
    mem_size_t lsz;
    // fill the window so every later load reads stored bytes
    for (int w = 0; w < region_words; w++) begin
      send_store(w * 8, mem_double);
    end
    for (int k = 0; k < n_ls_rounds; k++) begin
      lsz = random_size();
      off = aligned_offset(lsz);
      send_store(off, lsz);
      // same spot right behind the store, size and sign walk all combinations
      lsz = mem_size_t'(2'(k));
      send_load(off & ~((1 << lsz) - 1), lsz, 1'(k >> 2));
      lsz = random_size();
      send_load(aligned_offset(lsz), lsz, 1'(next_random() >> 31));
    end
  endtask

  task automatic run_records(input int kind, input int count);
    ex_rec_t r;
    for (int i = 0; i < count; i++) begin
      r = random_record();
      case (kind)
        1: begin
          if (i % 2 == 0) begin
            r.reg_ctrl = reg_ctrl_t'(1 << csr_to_reg);
          end else begin
            r.wen = 1'b0;
          end
        end
        // a few registers only, so writes to x0 and repeats are frequent
        2: r.rd = reg_addr_t'(next_random() >> 30);
        3: r.uart_valid = 1'(next_random() >> 31);
        default: ;
      endcase
      send(r, r.reg_ctrl[csr_to_reg] ? r.csr_data : r.ex_data);
    end
  endtask

  task automatic close_test(input string name, input int err0);
    if (errors == err0) begin
      passed++;
      $display("test %s: ok", name);
    end else begin
      failed++;
      $display("test %s: %0d errors", name, errors - err0);
    end
  endtask

  initial begin
    int err0;
    rst = 1'b1;
    // a live record sits on the inputs through reset, the stages must still come up empty
    in_valid = 1'b1;
    in_pc = '0;
    in_inst = '0;
    in_wen = 1'b1;
    in_rd = 5'd1;
    in_reg_ctrl = reg_ctrl_t'(1 << exe_to_reg);
    in_ex_data = '0;
    in_csr_data = '0;
    in_uart_valid = 1'b1;
    in_uart_char = '0;
    in_mem_ren = 1'b0;
    in_mem_wen = 1'b0;
    in_mem_size = mem_byte;
    in_mem_unsigned = 1'b0;
    in_store_data = '0;
    exp_data = '0;
    err0 = errors;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    in_valid <= 1'b0;
    in_wen <= 1'b0;
    in_uart_valid <= 1'b0;
    repeat (2) @(posedge clk);
    close_test("reset", err0);
    err0 = errors;
    run_load_store();
    drain();
    close_test("loads and stores", err0);
    err0 = errors;
    run_records(0, n_exe);
    drain();
    close_test("execute writeback", err0);
    err0 = errors;
    run_records(1, n_csr);
    drain();
    close_test("csr select and wen low", err0);
    err0 = errors;
    run_records(2, n_bypass);
    drain();
    close_test("read bypass and x0", err0);
    err0 = errors;
    run_records(3, n_uart);
    drain();
    close_test("serial output", err0);
    $display("tests passed %0d, failed %0d, mismatches %0d", passed, failed, errors);
    if (failed == 0 && errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // every record needs well under four cycles end to end
  initial begin
    #(clk_period * (n_records * 4 + 100));
    $display("timeout: records did not all commit in time");
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== logic/retire_unit.sv ====
// retire_unit: memory stage, data memory, writeback stage and register file
`timescale 1ns/10ps
`default_nettype none

module retire_unit
  import core_pkg::*;
  import mem_pkg::*;
#(
  parameter int DMEM_WORDS = dmem_words
) (
  input  logic            clk,
  input  logic            rst,
  // executed record from the execute stage
  input  logic            in_valid,
  input  logic [xlen-1:0] in_pc,
  input  logic [31:0]     in_inst,
  input  logic            in_wen,
  input  reg_addr_t       in_rd,
  input  reg_ctrl_t       in_reg_ctrl,
  input  logic [xlen-1:0] in_ex_data,
  input  logic [xlen-1:0] in_csr_data,
  input  logic            in_uart_valid,
  input  logic [7:0]      in_uart_char,
  input  logic            in_mem_ren,
  input  logic            in_mem_wen,
  input  mem_size_t       in_mem_size,
  input  logic            in_mem_unsigned,
  input  logic [xlen-1:0] in_store_data,
  output logic            in_ready,
  // operand reads for execute
  input  reg_addr_t       rs1_addr,
  output logic [xlen-1:0] rs1_data,
  input  reg_addr_t       rs2_addr,
  output logic [xlen-1:0] rs2_data,
  // commit side
  output logic            reg_wr_ena,
  output reg_addr_t       reg_wr_addr,
  output logic [xlen-1:0] reg_wr_data,
  output logic            commit_valid,
  output logic [xlen-1:0] commit_pc,
  output logic [31:0]     commit_inst,
  output logic            uart_out_valid,
  output logic [7:0]      uart_out_char
);

  localparam int aw = $clog2(DMEM_WORDS);

  ex_rec_t         in_rec;
  logic            dmem_en;
  logic            dmem_we;
  logic [7:0]      dmem_be;
  logic [aw-1:0]   dmem_addr;
  logic [xlen-1:0] dmem_wdata;
  logic [xlen-1:0] dmem_rdata;
  logic            mem_to_wb_valid;
  wb_rec_t         mem_to_wb_bus;
  logic            wb_allowin;

  assign in_rec = '{
    pc:           in_pc,
    inst:         in_inst,
    wen:          in_wen,
    rd:           in_rd,
    reg_ctrl:     in_reg_ctrl,
    ex_data:      in_ex_data,
    csr_data:     in_csr_data,
    uart_valid:   in_uart_valid,
    uart_char:    in_uart_char,
    mem_ren:      in_mem_ren,
    mem_wen:      in_mem_wen,
    mem_size:     in_mem_size,
    mem_unsigned: in_mem_unsigned,
    store_data:   in_store_data
  };

  mem_stage #(
    .DMEM_WORDS(DMEM_WORDS)
  ) mem_stage0 (
    .clk            (clk),
    .rst            (rst),
    .in_valid       (in_valid),
    .in_rec         (in_rec),
    .in_ready       (in_ready),
    .wb_allowin     (wb_allowin),
    .dmem_en        (dmem_en),
    .dmem_we        (dmem_we),
    .dmem_be        (dmem_be),
    .dmem_addr      (dmem_addr),
    .dmem_wdata     (dmem_wdata),
    .dmem_rdata     (dmem_rdata),
    .mem_to_wb_valid(mem_to_wb_valid),
    .mem_to_wb_bus  (mem_to_wb_bus)
  );

  data_mem #(
    .DMEM_WORDS(DMEM_WORDS)
  ) data_mem0 (
    .clk  (clk),
    .en   (dmem_en),
    .we   (dmem_we),
    .be   (dmem_be),
    .addr (dmem_addr),
    .wdata(dmem_wdata),
    .rdata(dmem_rdata)
  );

  wb_stage wb_stage0 (
    .clk            (clk),
    .rst            (rst),
    .mem_to_wb_valid(mem_to_wb_valid),
    .mem_to_wb_bus  (mem_to_wb_bus),
    .wb_allowin     (wb_allowin),
    .reg_wr_ena     (reg_wr_ena),
    .reg_wr_addr    (reg_wr_addr),
    .reg_wr_data    (reg_wr_data),
    .commit_valid   (commit_valid),
    .commit_pc      (commit_pc),
    .commit_inst    (commit_inst),
    .uart_out_valid (uart_out_valid),
    .uart_out_char  (uart_out_char)
  );

  regfile regfile0 (
    .clk     (clk),
    .rst     (rst),
    .wr_ena  (reg_wr_ena),
    .wr_addr (reg_wr_addr),
    .wr_data (reg_wr_data),
    .rs1_addr(rs1_addr),
    .rs1_data(rs1_data),
    .rs2_addr(rs2_addr),
    .rs2_data(rs2_data)
  );

endmodule

`default_nettype wire

// ==== logic/regfile.sv ====
// regfile: 32 x 64-bit integer registers, two read ports with write bypass
`timescale 1ns/10ps
`default_nettype none

module regfile
  import core_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  input  logic            wr_ena,
  input  reg_addr_t       wr_addr,
  input  logic [xlen-1:0] wr_data,
  input  reg_addr_t       rs1_addr,
  output logic [xlen-1:0] rs1_data,
  input  reg_addr_t       rs2_addr,
  output logic [xlen-1:0] rs2_data
);

  logic [xlen-1:0] regs [32];

  // x0 is never written, so it stays at its reset value of zero
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_ena && (wr_addr != '0)) begin
      regs[wr_addr] <= wr_data;
    end
  end

  function automatic logic [xlen-1:0] read_port(input reg_addr_t addr);
    logic [xlen-1:0] val;
    if (addr == '0) begin
      val = '0;
    end else if (wr_ena && (wr_addr == addr)) begin
      // forward the value being committed this cycle
      val = wr_data;
    end else begin
      val = regs[addr];
    end
    return val;
  endfunction

  assign rs1_data = read_port(rs1_addr);
  assign rs2_data = read_port(rs2_addr);

endmodule

`default_nettype wire

// ==== logic/wb_stage.sv ====
// wb_stage: writeback latch, write value select, register write and commit outputs
`timescale 1ns/10ps
`default_nettype none

module wb_stage
  import core_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  input  logic            mem_to_wb_valid,
  input  wb_rec_t         mem_to_wb_bus,
  output logic            wb_allowin,
  output logic            reg_wr_ena,
  output reg_addr_t       reg_wr_addr,
  output logic [xlen-1:0] reg_wr_data,
  output logic            commit_valid,
  output logic [xlen-1:0] commit_pc,
  output logic [31:0]     commit_inst,
  output logic            uart_out_valid,
  output logic [7:0]      uart_out_char
);

  logic            wb_valid;
  wb_rec_t         rec;
  logic [xlen-1:0] sel_data;

  // last stage, never stalls
  assign wb_allowin = 1'b1;

  stage_reg #(
    .payload_t(wb_rec_t)
  ) wb_reg0 (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (mem_to_wb_valid),
    .in_payload (mem_to_wb_bus),
    .allowin    (wb_allowin),
    .out_valid  (wb_valid),
    .out_payload(rec)
  );

  // and-or mux over the one-hot select
  assign sel_data =
      ({xlen{rec.reg_ctrl[exe_to_reg]}} & rec.ex_data)
    | ({xlen{rec.reg_ctrl[mem_to_reg]}} & rec.mem_data)
    | ({xlen{rec.reg_ctrl[csr_to_reg]}} & rec.csr_data);

  // everything outward is quiet without a valid record
  assign reg_wr_ena     = wb_valid && rec.wen;
  assign reg_wr_addr    = wb_valid ? rec.rd : '0;
  assign reg_wr_data    = wb_valid ? sel_data : '0;
  assign commit_valid   = wb_valid;
  assign commit_pc      = wb_valid ? rec.pc : '0;
  assign commit_inst    = wb_valid ? rec.inst : '0;
  assign uart_out_valid = wb_valid && rec.uart_valid;
  assign uart_out_char  = wb_valid ? rec.uart_char : '0;

  reg_ctrl_onehot_a: assert property (
    @(posedge clk) disable iff (rst)
    wb_valid |-> $onehot0(rec.reg_ctrl)
  );

endmodule

`default_nettype wire

// ==== logic/mem_stage.sv ====
// mem_stage: data memory access, execute record latch, load alignment and extension
`timescale 1ns/10ps
`default_nettype none

module mem_stage
  import core_pkg::*;
  import mem_pkg::*;
#(
  parameter int DMEM_WORDS = dmem_words
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          in_valid,
  input  ex_rec_t                       in_rec,
  output logic                          in_ready,
  input  logic                          wb_allowin,
  output logic                          dmem_en,
  output logic                          dmem_we,
  output logic [7:0]                    dmem_be,
  output logic [$clog2(DMEM_WORDS)-1:0] dmem_addr,
  output logic [xlen-1:0]               dmem_wdata,
  input  logic [xlen-1:0]               dmem_rdata,
  output logic                          mem_to_wb_valid,
  output wb_rec_t                       mem_to_wb_bus
);

  localparam int aw = $clog2(DMEM_WORDS);

  logic            mem_valid;
  logic            mem_allowin;
  logic            accept;
  logic [7:0]      size_mask;
  logic            misaligned;
  ex_rec_t         rec_q;
  logic [xlen-1:0] lane;
  logic [xlen-1:0] mem_data;

  // stage is ready every cycle, so only writeback can hold it
  assign mem_allowin = !mem_valid || wb_allowin;
  assign in_ready    = mem_allowin;
  assign accept      = in_valid && mem_allowin;

  always_comb begin
    size_mask  = 8'h01;
    misaligned = 1'b0;
    case (in_rec.mem_size)
      mem_byte: begin
        size_mask = 8'h01;
      end
      mem_half: begin
        size_mask  = 8'h03;
        misaligned = in_rec.ex_data[0];
      end
      mem_word: begin
        size_mask  = 8'h0f;
        misaligned = |in_rec.ex_data[1:0];
      end
      mem_double: begin
        size_mask  = 8'hff;
        misaligned = |in_rec.ex_data[2:0];
      end
      default: size_mask = 8'h01;
    endcase
  end

  // memory access happens on the edge that latches the record
  assign dmem_en    = accept && (in_rec.mem_ren || in_rec.mem_wen);
  assign dmem_we    = accept && in_rec.mem_wen;
  assign dmem_addr  = in_rec.ex_data[aw+2:3];
  assign dmem_be    = size_mask << in_rec.ex_data[2:0];
  assign dmem_wdata = in_rec.store_data << {in_rec.ex_data[2:0], 3'b000};

  stage_reg #(
    .payload_t(ex_rec_t)
  ) ex_reg0 (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_payload (in_rec),
    .allowin    (mem_allowin),
    .out_valid  (mem_valid),
    .out_payload(rec_q)
  );

  // move addressed bytes down to bit 0
  assign lane = dmem_rdata >> {rec_q.ex_data[2:0], 3'b000};

  always_comb begin
    case (rec_q.mem_size)
      mem_byte:
        mem_data = rec_q.mem_unsigned ? {{(xlen-8){1'b0}}, lane[7:0]}
                                      : {{(xlen-8){lane[7]}}, lane[7:0]};
      mem_half:
        mem_data = rec_q.mem_unsigned ? {{(xlen-16){1'b0}}, lane[15:0]}
                                      : {{(xlen-16){lane[15]}}, lane[15:0]};
      mem_word:
        mem_data = rec_q.mem_unsigned ? {{(xlen-32){1'b0}}, lane[31:0]}
                                      : {{(xlen-32){lane[31]}}, lane[31:0]};
      default:
        mem_data = lane;
    endcase
  end

  assign mem_to_wb_valid = mem_valid;
  assign mem_to_wb_bus = '{
    pc:         rec_q.pc,
    inst:       rec_q.inst,
    wen:        rec_q.wen,
    rd:         rec_q.rd,
    reg_ctrl:   rec_q.reg_ctrl,
    ex_data:    rec_q.ex_data,
    mem_data:   mem_data,
    csr_data:   rec_q.csr_data,
    uart_valid: rec_q.uart_valid,
    uart_char:  rec_q.uart_char
  };

  // natural alignment for every accepted access
  access_aligned_a: assert property (
    @(posedge clk) disable iff (rst)
    dmem_en |-> !misaligned
  );

endmodule

`default_nettype wire

// ==== logic/data_mem.sv ====
// data_mem: single-port synchronous data memory with byte-lane writes
`timescale 1ns/10ps
`default_nettype none

module data_mem
  import core_pkg::*;
  import mem_pkg::*;
#(
  parameter int DMEM_WORDS = dmem_words
) (
  input  logic                          clk,
  input  logic                          en,
  input  logic                          we,
  input  logic [7:0]                    be,
  input  logic [$clog2(DMEM_WORDS)-1:0] addr,
  input  logic [xlen-1:0]               wdata,
  output logic [xlen-1:0]               rdata
);

  logic [xlen-1:0] mem [DMEM_WORDS];

  // read-first, output registered
  always_ff @(posedge clk) begin
    if (en) begin
      rdata <= mem[addr];
    end
  end

  always_ff @(posedge clk) begin
    if (en && we) begin
      for (int i = 0; i < 8; i++) begin
        if (be[i]) begin
          mem[addr][i*8 +: 8] <= wdata[i*8 +: 8];
        end
      end
    end
  end

  // matters when the depth is not a power of two
  addr_range_a: assert property (
    @(posedge clk) en |-> (int'(addr) < DMEM_WORDS)
  );

endmodule

`default_nettype wire

// ==== logic/stage_reg.sv ====
// stage_reg: valid/allowin pipeline register for an arbitrary record type
`timescale 1ns/10ps
`default_nettype none

module stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     in_valid,
  input  payload_t in_payload,
  input  logic     allowin,
  output logic     out_valid,
  output payload_t out_payload
);

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (allowin) begin
      out_valid <= in_valid;
    end
  end

  // payload only moves on an accepted record, otherwise holds
  always_ff @(posedge clk) begin
    if (in_valid && allowin) begin
      out_payload <= in_payload;
    end
  end

  // a valid record never carries X bits downstream
  payload_known_a: assert property (
    @(posedge clk) disable iff (rst)
    out_valid |-> !$isunknown(out_payload)
  );

endmodule

`default_nettype wire

// ==== logic/mem_pkg.sv ====
// access size encoding, data memory depth and the execute to memory record
`default_nettype none

package mem_pkg;

  import core_pkg::*;

  typedef enum logic [1:0] {
    mem_byte   = 2'd0,
    mem_half   = 2'd1,
    mem_word   = 2'd2,
    mem_double = 2'd3
  } mem_size_t;

  // default data memory depth in 64-bit words
  localparam int dmem_words = 256;

  // record delivered by the execute stage
  // ex_data doubles as the memory address for loads and stores
  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [31:0]     inst;
    logic            wen;
    reg_addr_t       rd;
    reg_ctrl_t       reg_ctrl;
    logic [xlen-1:0] ex_data;
    logic [xlen-1:0] csr_data;
    logic            uart_valid;
    logic [7:0]      uart_char;
    logic            mem_ren;
    logic            mem_wen;
    mem_size_t       mem_size;
    logic            mem_unsigned;
    logic [xlen-1:0] store_data;
  } ex_rec_t;

endpackage

`default_nettype wire

// ==== logic/core_pkg.sv ====
// core widths, writeback select encoding and the memory to writeback record
`default_nettype none

package core_pkg;

  // integer data width
  localparam int xlen = 64;

  typedef logic [4:0] reg_addr_t;

  // one-hot writeback source select
  typedef logic [2:0] reg_ctrl_t;

  // bit positions inside reg_ctrl_t
  localparam int exe_to_reg = 0;
  localparam int mem_to_reg = 1;
  localparam int csr_to_reg = 2;

  // record handed from the memory stage to writeback
  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [31:0]     inst;
    logic            wen;
    reg_addr_t       rd;
    reg_ctrl_t       reg_ctrl;
    logic [xlen-1:0] ex_data;
    // load data, already aligned and extended
    logic [xlen-1:0] mem_data;
    logic [xlen-1:0] csr_data;
    logic            uart_valid;
    logic [7:0]      uart_char;
  } wb_rec_t;

endpackage

`default_nettype wire
